// ==== hw/det_nn.sv ====
`timescale 1ns/1ps
`include "det_nn_consts.svh"

module det_nn import det_nn_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [`NN_PIXELS*`NN_PIX_W-1:0] data_in,     // Pixel i at bits 8i+7:8i
  input  logic                             write_weight,
  input  logic                             layer_sel,
  input  nidx_t                            neuron_sel,
  input  widx_t                            weight_sel,
  input  fix_t                             weight_bus,
  output logic                             result,
  output fix_t                             score,
  output logic                             done
);

  waddr_t rd_addr;
  fix_t   rd_data;

  mac_if u_bus ();

  // ##########################################################################
  // Weight memory
  // ##########################################################################

  weight_store u_weights (
    .clk          (clk),
    .rst_n        (rst_n),
    .write_weight (write_weight),
    .layer_sel    (layer_sel),
    .neuron_sel   (neuron_sel),
    .weight_sel   (weight_sel),
    .weight_bus   (weight_bus),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  // ##########################################################################
  // Shared MAC engine and its sequencer
  // ##########################################################################

  neuron_mac u_mac (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (u_bus.mac),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  layer_sequencer u_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .data_in (data_in),
    .bus     (u_bus.seq),
    .result  (result),
    .score   (score),
    .done    (done)
  );

endmodule

// ==== hw/det_nn_consts.svh ====
`ifndef DET_NN_CONSTS_SVH
`define DET_NN_CONSTS_SVH

// Network shape
`define NN_PIXELS      32
`define NN_HIDDEN      4
`define NN_HID_INPUTS  8
`define NN_OUT_INPUTS  4

// Fixed point, Q8.8 values and Q24.16 accumulator
`define NN_PIX_W       8
`define NN_FIX_W       16
`define NN_ACC_W       40
`define NN_FRAC        8

// Decision threshold, -0.25 in Q8.8
`define NN_THRESHOLD   (-16'sd64)

// Weight port and flat memory addressing
`define NN_WADDR_W     6
`define NN_NIDX_W      2
`define NN_WIDX_W      4

`endif

// ==== hw/det_nn_pkg.sv ====
`include "det_nn_consts.svh"

package det_nn_pkg;

  typedef logic        [`NN_PIX_W-1:0]   pixel_t;  // Raw pixel byte
  typedef logic signed [`NN_FIX_W-1:0]   fix_t;    // Q8.8
  typedef logic signed [`NN_ACC_W-1:0]   acc_t;    // Q24.16
  typedef logic        [`NN_WADDR_W-1:0] waddr_t;
  typedef logic        [`NN_NIDX_W-1:0]  nidx_t;   // Neuron select
  typedef logic        [`NN_WIDX_W-1:0]  widx_t;   // Weight index, bias included

  typedef enum logic [2:0] {
    IDLE,
    RUN_HIDDEN,
    WAIT_HIDDEN,
    RUN_OUT,
    WAIT_OUT,
    DECIDE
  } seq_state_t;

  // Flat address is {layer, neuron, idx[2:0]}. A hidden bias (idx 8) has no
  // room there, so it sits in slot 7 of the layer 1 block, which the output
  // neuron never uses
  function automatic waddr_t weight_addr(logic layer, nidx_t neuron, widx_t idx);
    if (!layer && idx == widx_t'(`NN_HID_INPUTS)) begin
      return {1'b1, neuron, 3'b111};
    end
    return {layer, neuron, idx[2:0]};
  endfunction

endpackage

// ==== hw/layer_sequencer.sv ====
`timescale 1ns/1ps
`include "det_nn_consts.svh"

module layer_sequencer import det_nn_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [`NN_PIXELS*`NN_PIX_W-1:0] data_in,
  mac_if.seq                               bus,
  output logic                             result,
  output fix_t                             score,
  output logic                             done
);

  localparam fix_t THRESH = fix_t'(`NN_THRESHOLD);

  seq_state_t state;
  nidx_t      cnt;                    // Hidden neuron in progress
  logic       out_phase;
  pixel_t     frame  [`NN_PIXELS];
  fix_t       hidden [`NN_HIDDEN];
  pixel_t     pixel;

  // ##########################################################################
  // Engine operands
  // ##########################################################################

  assign out_phase  = (state == RUN_OUT) || (state == WAIT_OUT);
  assign bus.start  = (state == RUN_HIDDEN) || (state == RUN_OUT);
  assign bus.layer  = out_phase;
  assign bus.neuron = cnt;            // Wrapped to 0 for the output neuron

  // Neuron n reads pixels 8n..8n+7
  assign pixel = frame[{cnt, bus.idx[2:0]}];

  // A pixel byte is already pixel/256 as a Q8.8 fraction
  assign bus.operand = out_phase ? hidden[bus.idx[1:0]] : fix_t'(pixel);

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      for (int i = 0; i < `NN_PIXELS; i++) begin
        frame[i] <= data_in[i*`NN_PIX_W +: `NN_PIX_W];
      end
    end
    if (state == WAIT_HIDDEN && bus.done) begin
      hidden[cnt] <= bus.activation;
    end
  end

  // ##########################################################################
  // Sequencing and decision
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      cnt    <= '0;
      result <= 1'b0;
      score  <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            cnt   <= '0;
            state <= RUN_HIDDEN;
          end
        end
        RUN_HIDDEN: state <= WAIT_HIDDEN;
        WAIT_HIDDEN: begin
          if (bus.done) begin
            cnt <= cnt + 1'b1;
            if (cnt == nidx_t'(`NN_HIDDEN - 1)) begin
              state <= RUN_OUT;
            end else begin
              state <= RUN_HIDDEN;
            end
          end
        end
        RUN_OUT: state <= WAIT_OUT;
        WAIT_OUT: begin
          if (bus.done) begin
            state <= DECIDE;
          end
        end
        DECIDE: begin
          score  <= bus.activation;               // Engine holds it after done
          result <= (bus.activation >= THRESH);   // Signed compare
          done   <= 1'b1;
          state  <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_done_after_decide: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> ($past(state) == DECIDE)
  ) else $error("done outside the cycle after DECIDE");

endmodule

// ==== hw/mac_if.sv ====
`timescale 1ns/1ps

interface mac_if import det_nn_pkg::*; ();

  logic  start;       // One cycle pulse
  logic  layer;       // 0 hidden, 1 output
  nidx_t neuron;
  fix_t  operand;     // Input for the current idx
  widx_t idx;
  fix_t  activation;
  logic  done;        // One cycle pulse

  modport seq (
    output start,
    output layer,
    output neuron,
    output operand,
    input  idx,
    input  activation,
    input  done
  );

  modport mac (
    input  start,
    input  layer,
    input  neuron,
    input  operand,
    output idx,
    output activation,
    output done
  );

endinterface

// ==== hw/neuron_mac.sv ====
`timescale 1ns/1ps
`include "det_nn_consts.svh"

module neuron_mac import det_nn_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  mac_if.mac     bus,
  output waddr_t rd_addr,
  input  fix_t   rd_data
);

  localparam acc_t ONE     = acc_t'(1) <<< `NN_FRAC;               // 1.0 in Q8.8
  localparam acc_t FIX_MAX = (acc_t'(1) <<< (`NN_FIX_W - 1)) - 1;
  localparam acc_t FIX_MIN = -(acc_t'(1) <<< (`NN_FIX_W - 1));

  logic  busy;          // Issuing reads
  logic  term_v;        // rd_data matches op_q
  logic  last_q;        // Current term is the bias
  logic  layer_q;
  nidx_t neuron_q;
  widx_t idx;
  widx_t n_inputs;
  fix_t  op_q;
  acc_t  acc;
  acc_t  product;
  acc_t  term;
  acc_t  sum;
  acc_t  shifted;
  acc_t  lim_hi;
  acc_t  lim_lo;
  fix_t  act_next;
  fix_t  activation;
  logic  done;

  assign n_inputs = layer_q ? widx_t'(`NN_OUT_INPUTS) : widx_t'(`NN_HID_INPUTS);
  assign rd_addr  = weight_addr(layer_q, neuron_q, idx);

  // ##########################################################################
  // Datapath
  // ##########################################################################

  assign product = op_q * rd_data;                                  // Q.16
  assign term    = last_q ? (acc_t'(rd_data) <<< `NN_FRAC) : product;
  assign sum     = acc + term;
  assign shifted = sum >>> `NN_FRAC;                                // Back to Q8.8

  // Hard tanh for the hidden layer, plain saturation at the output
  assign lim_hi = layer_q ? FIX_MAX : ONE;
  assign lim_lo = layer_q ? FIX_MIN : -ONE;

  always_comb begin
    if (shifted > lim_hi) begin
      act_next = fix_t'(lim_hi);
    end else if (shifted < lim_lo) begin
      act_next = fix_t'(lim_lo);
    end else begin
      act_next = fix_t'(shifted);
    end
  end

  // Operand lines up with the weight read one cycle later
  always_ff @(posedge clk) begin
    op_q <= bus.operand;
  end

  // ##########################################################################
  // Control
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      idx        <= '0;
      term_v     <= 1'b0;
      last_q     <= 1'b0;
      layer_q    <= 1'b0;
      neuron_q   <= '0;
      acc        <= '0;
      activation <= '0;
      done       <= 1'b0;
    end else begin
      term_v <= busy;
      last_q <= busy && (idx == n_inputs);
      done   <= 1'b0;

      if (bus.start) begin
        busy     <= 1'b1;
        idx      <= '0;
        layer_q  <= bus.layer;
        neuron_q <= bus.neuron;
      end else if (busy) begin
        if (idx == n_inputs) begin    // Bias was the last read
          busy <= 1'b0;
          idx  <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end

      if (term_v) begin
        if (last_q) begin
          activation <= act_next;
          done       <= 1'b1;
          acc        <= '0;
        end else begin
          acc <= sum;
        end
      end
    end
  end

  assign bus.idx        = idx;
  assign bus.activation = activation;
  assign bus.done       = done;

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n) bus.start |-> !(busy || term_v)
  ) else $error("neuron start while engine busy");

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) bus.done |=> !bus.done
  ) else $error("engine done longer than one cycle");

endmodule

// ==== hw/weight_store.sv ====
`timescale 1ns/1ps
`include "det_nn_consts.svh"

module weight_store import det_nn_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   write_weight,
  input  logic   layer_sel,
  input  nidx_t  neuron_sel,
  input  widx_t  weight_sel,
  input  fix_t   weight_bus,
  input  waddr_t rd_addr,
  output fix_t   rd_data
);

  localparam int DEPTH = 1 << `NN_WADDR_W;

  fix_t   mem [DEPTH];
  logic   wr_ok;
  waddr_t wr_addr;
  logic   slot_used;

  // ##########################################################################
  // Write decode
  // ##########################################################################

  always_comb begin
    if (layer_sel) begin
      // Single output neuron, 4 weights and a bias
      wr_ok = write_weight && (neuron_sel == '0) &&
              (weight_sel <= widx_t'(`NN_OUT_INPUTS));
    end else begin
      wr_ok = write_weight && (weight_sel <= widx_t'(`NN_HID_INPUTS));
    end
  end

  assign wr_addr = weight_addr(layer_sel, neuron_sel, weight_sel);

  // ##########################################################################
  // Storage and registered read
  // ##########################################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rd_data <= '0;
    end else begin
      if (wr_ok) begin
        mem[wr_addr] <= weight_bus;
      end
      rd_data <= mem[rd_addr];    // One cycle read lag
    end
  end

  // Hidden weights, hidden biases in slot 7 of layer 1, output neuron 0..4
  assign slot_used = !rd_addr[5] ||
                     (rd_addr[2:0] == 3'b111) ||
                     (rd_addr[4:3] == 2'b00 && rd_addr[2:0] <= 3'd4);

  a_rd_slot_used: assert property (
    @(posedge clk) disable iff (!rst_n) slot_used
  ) else $error("weight read from unused slot %0d", rd_addr);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the det_nn testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_det_nn -o sim_tb_det_nn
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_det_nn)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/tb_det_nn_model.svh ====
`ifndef TB_DET_NN_MODEL_SVH
`define TB_DET_NN_MODEL_SVH

// Shadow of the weight memory, bias in the last slot of each neuron
fix_t hid_w [`NN_HIDDEN][`NN_HID_INPUTS+1];
fix_t out_w [`NN_OUT_INPUTS+1];

// One write through the port, then the shadow if the write is in range
task automatic put_weight(input logic layer, input int neuron, input int sel,
                          input fix_t value);
  @(posedge clk);
  #1;
  write_weight = 1'b1;
  layer_sel    = layer;
  neuron_sel   = nidx_t'(neuron);
  weight_sel   = widx_t'(sel);
  weight_bus   = value;
  @(posedge clk);
  #1;
  write_weight = 1'b0;
  if (!layer && sel <= `NN_HID_INPUTS) begin
    hid_w[neuron][sel] = value;
  end else if (layer && neuron == 0 && sel <= `NN_OUT_INPUTS) begin
    out_w[sel] = value;
  end
endtask

task automatic zero_weights();
  for (int n = 0; n < `NN_HIDDEN; n++) begin
    for (int i = 0; i <= `NN_HID_INPUTS; i++) begin
      put_weight(1'b0, n, i, '0);
    end
  end
  for (int i = 0; i <= `NN_OUT_INPUTS; i++) begin
    put_weight(1'b1, 0, i, '0);
  end
endtask

// Every hidden input weight, biases untouched
task automatic fill_hidden(input fix_t value);
  for (int n = 0; n < `NN_HIDDEN; n++) begin
    for (int i = 0; i < `NN_HID_INPUTS; i++) begin
      put_weight(1'b0, n, i, value);
    end
  end
endtask

function automatic fix_t rand_fix(input int span);
  return fix_t'(int'($urandom_range(2 * span)) - span);
endfunction

task automatic random_weights();
  for (int n = 0; n < `NN_HIDDEN; n++) begin
    for (int i = 0; i <= `NN_HID_INPUTS; i++) begin
      put_weight(1'b0, n, i, (i == `NN_HID_INPUTS) ? rand_fix(128) : rand_fix(64));
    end
  end
  for (int i = 0; i <= `NN_OUT_INPUTS; i++) begin
    put_weight(1'b1, 0, i, (i == `NN_OUT_INPUTS) ? rand_fix(128) : rand_fix(256));
  end
endtask

function automatic frame_t random_frame();
  frame_t f;
  for (int p = 0; p < `NN_PIXELS; p++) begin
    f[p*`NN_PIX_W +: `NN_PIX_W] = 8'($urandom_range(255));
  end
  return f;
endfunction

// Pixel byte taken as a Q8.8 fraction, products in Q16
function automatic fix_t model_score(input frame_t frame);
  longint acc;
  longint act [`NN_HIDDEN];
  longint px;
  for (int n = 0; n < `NN_HIDDEN; n++) begin
    acc = 0;
    for (int i = 0; i < `NN_HID_INPUTS; i++) begin
      px  = longint'(frame[(n*`NN_HID_INPUTS + i)*`NN_PIX_W +: `NN_PIX_W]);
      acc += px * longint'(hid_w[n][i]);
    end
    acc += longint'(hid_w[n][`NN_HID_INPUTS]) * 256;
    acc = acc >>> `NN_FRAC;
    if (acc > 256) acc = 256;      // Hard tanh
    if (acc < -256) acc = -256;
    act[n] = acc;
  end
  acc = 0;
  for (int i = 0; i < `NN_OUT_INPUTS; i++) begin
    acc += act[i] * longint'(out_w[i]);
  end
  acc += longint'(out_w[`NN_OUT_INPUTS]) * 256;
  acc = acc >>> `NN_FRAC;
  if (acc > 32767) acc = 32767;
  if (acc < -32768) acc = -32768;
  return fix_t'(acc);
endfunction

function automatic logic model_result(input fix_t s);
  return s >= fix_t'(`NN_THRESHOLD);
endfunction

`endif

// ==== testbench/tb_det_nn.sv ====
`timescale 1ns/1ps
`include "det_nn_consts.svh"

module tb_det_nn import det_nn_pkg::*; ();

  typedef logic [`NN_PIXELS*`NN_PIX_W-1:0] frame_t;

  localparam int RUNS        = 26;
  localparam int LOAD_CYCLES = 2 * 1000;        // About a thousand writes, two cycles each
  localparam int TIMEOUT_NS  = (RUNS + LOAD_CYCLES) * 200 * 8;
  localparam int DONE_LIMIT  = 500;

  logic   clk;
  logic   rst_n;
  logic   start;
  frame_t data_in;
  logic   write_weight;
  logic   layer_sel;
  nidx_t  neuron_sel;
  widx_t  weight_sel;
  fix_t   weight_bus;
  logic   result;
  fix_t   score;
  logic   done;

  logic   started;
  logic   expect_done;                          // A run is open
  fix_t   exp_score;
  logic   exp_result;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     failed_tests = 0;

  `include "tb_det_nn_model.svh"

  det_nn dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .data_in      (data_in),
    .write_weight (write_weight),
    .layer_sel    (layer_sel),
    .neuron_sel   (neuron_sel),
    .weight_sel   (weight_sel),
    .weight_bus   (weight_bus),
    .result       (result),
    .score        (score),
    .done         (done)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n && done) checks <= checks + 1;
  end

  // ##########################################################################
  // Checks
  // ##########################################################################

  a_quiet_before_start: assert property (
    @(posedge clk) disable iff (!rst_n) !started |-> (!done && !result && score == '0)
  ) else begin
    errors = errors + 1;
    $display("MISMATCH %0t: outputs not zero before the first start", $time);
  end

  a_score_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |-> (score == exp_score && result == exp_result)
  ) else begin
    errors = errors + 1;
    $display("MISMATCH %0t: score %0d result %0b, expected score %0d result %0b",
             $time, score, result, exp_score, exp_result);
  end

  a_single_done: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> expect_done
  ) else begin
    errors = errors + 1;
    $display("Unexpected done pulse at %0t with no run open", $time);
  end

  // ##########################################################################
  // Stimulus
  // ##########################################################################

  task automatic launch(input frame_t frame);
    exp_score  = model_score(frame);
    exp_result = model_result(exp_score);
    @(posedge clk);
    #1;
    data_in     = frame;
    start       = 1'b1;
    started     = 1'b1;
    expect_done = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!done && cycles < DONE_LIMIT);
    if (!done) begin
      errors = errors + 1;
      $display("No done from the DUT within %0d cycles at %0t", DONE_LIMIT, $time);
    end
    @(posedge clk);
    #1;
    expect_done = 1'b0;                         // Closed after the done edge is checked
  endtask

  task automatic run_frame(input frame_t frame);
    launch(frame);
    wait_done();
  endtask

  task automatic finish_test(input string name, input int base);
    tests++;
    if (errors > base) begin
      failed_tests++;
      $display("test %0d %s: FAIL", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
  endtask

  initial begin
    int     base;
    frame_t frame;
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    data_in      = '0;
    write_weight = 1'b0;
    layer_sel    = 1'b0;
    neuron_sel   = '0;
    weight_sel   = '0;
    weight_bus   = '0;
    started      = 1'b0;
    expect_done  = 1'b0;
    exp_score    = '0;
    exp_result   = 1'b0;
    void'($urandom(64));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5) @(posedge clk);
    finish_test("reset values", 0);

    // Single path pixel 11 through hidden neuron 1
    base = errors;
    zero_weights();
    put_weight(1'b0, 1, 3, 16'sh0100);
    put_weight(1'b1, 0, 1, 16'sh0100);
    frame = random_frame();
    frame[11*8 +: 8] = 8'hA0;
    run_frame(frame);
    put_weight(1'b1, 0, 1, -16'sh0100);
    frame[11*8 +: 8] = 8'h30;                   // Just above the threshold
    run_frame(frame);
    frame[11*8 +: 8] = 8'h50;
    run_frame(frame);
    finish_test("hand set weights", base);

    base = errors;
    fill_hidden(16'sh0200);
    put_weight(1'b1, 0, 0, 16'sh4000);
    put_weight(1'b1, 0, 1, 16'sh3000);
    put_weight(1'b1, 0, 2, 16'sh2000);
    put_weight(1'b1, 0, 3, 16'sh1000);
    put_weight(1'b1, 0, 4, 16'sh1000);
    run_frame({`NN_PIXELS{8'hFF}});
    finish_test("hidden saturation", base);

    base = errors;
    repeat (20) begin
      random_weights();
      run_frame(random_frame());
    end
    finish_test("random runs", base);

    // Second start with new data while busy
    base = errors;
    frame = random_frame();
    launch(frame);
    repeat (6) @(posedge clk);
    #1;
    start   = 1'b1;
    data_in = ~frame;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_done();
    repeat (100) @(posedge clk);
    finish_test("start during run", base);

    base = errors;
    random_weights();
    for (int s = 9; s < 16; s++) begin
      put_weight(1'b0, s % 4, s, 16'sh7F00);
    end
    for (int n = 1; n < 4; n++) begin
      for (int s = 0; s <= `NN_OUT_INPUTS; s++) begin
        put_weight(1'b1, n, s, 16'sh7F00);
      end
    end
    for (int s = 5; s < 16; s++) begin
      put_weight(1'b1, 0, s, 16'sh7F00);
    end
    run_frame(random_frame());
    finish_test("ignored writes", base);

    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
+incdir+testbench
hw/det_nn_pkg.sv
hw/mac_if.sv
hw/weight_store.sv
hw/neuron_mac.sv
hw/layer_sequencer.sv
hw/det_nn.sv
testbench/tb_det_nn.sv
